//--- Makefile
# Verilator build and run of the unsharp testbench

VERILATOR ?= verilator
TOP       ?= tb_unsharp
FILELIST  ?= unsharp.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)

//--- design/line_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "unsharp_defines.svh"

module line_buffer import unsharp_pkg::*; (
  input  wire logic   clk,
  input  wire logic   rstb,
  input  wire logic   i_shift,   // advance one column
  input  wire pixel_t i_pix,     // newest pixel
  output pixel_t      o_up1,     // one row above, current column
  output pixel_t      o_up2,     // two rows above, current column
  output logic        o_last_col
);

  localparam col_t LAST_COL = col_t'(`UNSHARP_IMG_W - 1);

  // mem1 holds the previous row, mem2 the one before
  pixel_t mem1 [`UNSHARP_IMG_W];
  pixel_t mem2 [`UNSHARP_IMG_W];
  col_t   addr;

  // column pointer, shared by both rows
  always_ff @(posedge clk or negedge rstb) begin
    if (!rstb) begin
      addr <= '0;
    end else if (i_shift) begin
      addr <= (addr == LAST_COL) ? '0 : addr + col_t'(1); // wrap at row end
    end
  end

  // write new pixel, push old row one step further up
  always_ff @(posedge clk) begin
    if (i_shift) begin
      mem1[addr] <= i_pix;
      mem2[addr] <= mem1[addr];
    end
  end

  assign o_up1      = mem1[addr]; // read before overwrite
  assign o_up2      = mem2[addr];
  assign o_last_col = (addr == LAST_COL);

endmodule

`default_nettype wire

//--- design/sharpen_pipe.sv
`timescale 1ns/1ps
`default_nettype none

`include "unsharp_defines.svh"

module sharpen_pipe import unsharp_pkg::*; #(
  parameter int WEIGHT = `UNSHARP_WEIGHT
) (
  input  wire logic    clk,
  input  wire logic    rstb,
  input  wire window_t i_win,
  input  wire logic    i_win_valid,
  output pixel_t       o_pix,
  output logic         o_valid
);

  localparam int DW     = `UNSHARP_DATA_W;
  localparam int SUM_W  = DW + 4;                            // nine pixels
  localparam int PROD_W = DW + `UNSHARP_MEAN_SHIFT;          // mean sits in the top DW bits
  localparam int ENH_W  = DW + 2 + $clog2(WEIGHT + 1);       // sign + headroom for the gain
  localparam logic signed [ENH_W-1:0] WEIGHT_S = ENH_W'(WEIGHT);

  logic [9:0]              vld_q;     // valid, one bit per stage
  window_t                 win_q;
  pixel_t                  ctr_q [6]; // centre, stages 2..7
  logic [DW:0]             sum2_q [4];
  logic [DW+1:0]           sum3_q [2];
  logic [DW+2:0]           sum4_q;
  logic [SUM_W-1:0]        sum5_q;
  logic [PROD_W-1:0]       prod_q;
  pixel_t                  mean_q;
  pixel_t                  mean_d_q;
  logic signed [DW:0]      edge_q;    // centre - mean
  logic signed [ENH_W-1:0] edge_ext;
  logic signed [ENH_W-1:0] mean_ext;
  logic signed [ENH_W-1:0] enh_q;

  always_ff @(posedge clk or negedge rstb) begin
    if (!rstb) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[8:0], i_win_valid};
    end
  end

  always_ff @(posedge clk) begin
    win_q     <= i_win;                                          // 1
    sum2_q[0] <= {1'b0, win_q.tl} + {1'b0, win_q.tm};            // 2
    sum2_q[1] <= {1'b0, win_q.tr} + {1'b0, win_q.ml};
    sum2_q[2] <= {1'b0, win_q.mr} + {1'b0, win_q.bl};
    sum2_q[3] <= {1'b0, win_q.bm} + {1'b0, win_q.br};
    sum3_q[0] <= {1'b0, sum2_q[0]} + {1'b0, sum2_q[1]};          // 3
    sum3_q[1] <= {1'b0, sum2_q[2]} + {1'b0, sum2_q[3]};
    sum4_q    <= {1'b0, sum3_q[0]} + {1'b0, sum3_q[1]};          // 4
    sum5_q    <= {1'b0, sum4_q} + SUM_W'(ctr_q[2]);              // 5, centre joins here
    prod_q    <= PROD_W'(sum5_q * `UNSHARP_MEAN_MUL);            // 6
    mean_q    <= prod_q[PROD_W-1 -: DW];                         // 7
    edge_q    <= $signed({1'b0, ctr_q[5]}) - $signed({1'b0, mean_q}); // 8
    mean_d_q  <= mean_q;
    enh_q     <= mean_ext + WEIGHT_S * edge_ext;                 // 9
  end

  // centre pixel follows the sum tree
  always_ff @(posedge clk) begin
    ctr_q[0] <= win_q.mc;
    for (int i = 1; i < 6; i++) begin
      ctr_q[i] <= ctr_q[i-1];
    end
  end

  assign edge_ext = $signed({{(ENH_W-DW-1){edge_q[DW]}}, edge_q}); // sign extend
  assign mean_ext = $signed({{(ENH_W-DW){1'b0}}, mean_d_q});

  // 10, clamp to pixel range
  always_ff @(posedge clk) begin
    if (enh_q[ENH_W-1]) begin
      o_pix <= '0;                 // undershoot
    end else if (|enh_q[ENH_W-2:DW]) begin
      o_pix <= '1;                 // overshoot past 255
    end else begin
      o_pix <= enh_q[DW-1:0];
    end
  end

  assign o_valid = vld_q[9];

endmodule

`default_nettype wire

//--- design/unsharp_defines.svh
`ifndef UNSHARP_DEFINES_SVH
`define UNSHARP_DEFINES_SVH

// pixel format
`define UNSHARP_DATA_W 8

// frame geometry, small default keeps sims short
`define UNSHARP_IMG_W 8
`define UNSHARP_IMG_H 8

// enhancement gain on the edge term
`define UNSHARP_WEIGHT 2

// mean ~= sum * 28 / 256, close to sum / 9
`define UNSHARP_MEAN_MUL 28
`define UNSHARP_MEAN_SHIFT 8

`endif

//--- design/unsharp_pkg.sv
`default_nettype none

`include "unsharp_defines.svh"

package unsharp_pkg;

  typedef logic [`UNSHARP_DATA_W-1:0] pixel_t;
  typedef logic [$clog2(`UNSHARP_IMG_W)-1:0] col_t; // column / line buffer address
  typedef logic [$clog2(`UNSHARP_IMG_H)-1:0] row_t; // row count within a frame

  // one raster beat from the source
  typedef struct packed {
    logic   hav; // horizontal active
    logic   vav; // vertical active
    pixel_t pix;
  } raster_t;

  // 3x3 neighbourhood, t = older row, b = newest row
  typedef struct packed {
    pixel_t tl;
    pixel_t tm;
    pixel_t tr;
    pixel_t ml;
    pixel_t mc; // centre
    pixel_t mr;
    pixel_t bl;
    pixel_t bm;
    pixel_t br;
  } window_t;

  typedef enum logic [3:0] {
    IDLE,
    FIRST_LEFT,
    FIRST_MID,
    FIRST_RIGHT,
    BODY_LEFT,
    BODY_MID,
    BODY_RIGHT,
    FLUSH_WAIT, // last row stored, waiting for vav to drop
    LAST_LEFT,
    LAST_MID,
    LAST_RIGHT
  } border_e;

endpackage

`default_nettype wire

//--- design/unsharp_top.sv
`timescale 1ns/1ps
`default_nettype none

module unsharp_top import unsharp_pkg::*; (
  input  wire logic    clk,
  input  wire logic    rstb,
  input  wire raster_t i_raster,
  output pixel_t       o_pix,
  output logic         o_valid
);

  logic    shift;     // one column step of the line buffer
  pixel_t  new_pix;
  pixel_t  up1;
  pixel_t  up2;
  logic    last_col;
  window_t win;
  logic    win_valid;

  // raster tracking and border handling
  window_former u_window_former (
    .clk         (clk),
    .rstb        (rstb),
    .i_raster    (i_raster),
    .i_up1       (up1),
    .i_up2       (up2),
    .i_last_col  (last_col),
    .o_shift     (shift),
    .o_pix       (new_pix),
    .o_win       (win),
    .o_win_valid (win_valid)
  );

  // previous two rows
  line_buffer u_line_buffer (
    .clk        (clk),
    .rstb       (rstb),
    .i_shift    (shift),
    .i_pix      (new_pix),
    .o_up1      (up1),
    .o_up2      (up2),
    .o_last_col (last_col)
  );

  // fixed 10-cycle arithmetic
  sharpen_pipe u_sharpen_pipe (
    .clk         (clk),
    .rstb        (rstb),
    .i_win       (win),
    .i_win_valid (win_valid),
    .o_pix       (o_pix),
    .o_valid     (o_valid)
  );

endmodule

`default_nettype wire

//--- design/window_former.sv
`timescale 1ns/1ps
`default_nettype none

`include "unsharp_defines.svh"

module window_former import unsharp_pkg::*; (
  input  wire logic    clk,
  input  wire logic    rstb,
  input  wire raster_t i_raster,
  input  wire pixel_t  i_up1,      // line buffer, row above
  input  wire pixel_t  i_up2,      // line buffer, two rows above
  input  wire logic    i_last_col,
  output logic         o_shift,
  output pixel_t       o_pix,
  output window_t      o_win,
  output logic         o_win_valid
);

  localparam row_t LAST_ROW = row_t'(`UNSHARP_IMG_H - 1);

  logic    hav_q;
  logic    vav_q;
  pixel_t  pix_q;
  logic    act;       // registered pixel is live
  logic    act_d;
  logic    row_end;
  row_t    row_cnt;
  border_e state;
  border_e state_nxt;
  logic    flush;     // shifting out the last row
  logic    shift;
  // tap chains, d1 = centre column, d2 = left column
  pixel_t  bot_d1;
  pixel_t  bot_d2;
  pixel_t  mid_d1;
  pixel_t  mid_d2;
  pixel_t  top_d1;
  pixel_t  top_d2;
  // rows picked for the top and bottom of the window
  pixel_t  t_l;
  pixel_t  t_c;
  pixel_t  t_r;
  pixel_t  b_l;
  pixel_t  b_c;
  pixel_t  b_r;
  logic    at_left;
  logic    at_right;

  // input register, flags only get reset
  always_ff @(posedge clk or negedge rstb) begin
    if (!rstb) begin
      hav_q <= 1'b0;
      vav_q <= 1'b0;
      act_d <= 1'b0;
    end else begin
      hav_q <= i_raster.hav;
      vav_q <= i_raster.vav;
      act_d <= act;
    end
  end

  always_ff @(posedge clk) begin
    pix_q <= i_raster.pix;
  end

  assign act     = hav_q & vav_q;
  assign row_end = act_d & ~act; // falling edge of the active row

  always_ff @(posedge clk or negedge rstb) begin
    if (!rstb) begin
      row_cnt <= '0;
    end else if (row_end) begin
      row_cnt <= (row_cnt == LAST_ROW) ? '0 : row_cnt + row_t'(1);
    end
  end

  always_ff @(posedge clk or negedge rstb) begin
    if (!rstb) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (act && row_cnt == row_t'(1)) state_nxt = FIRST_LEFT; // row 0 only fills mem1
        else if (act && row_cnt != '0)   state_nxt = BODY_LEFT;
      end
      FIRST_LEFT:  state_nxt = FIRST_MID;
      FIRST_MID:   state_nxt = i_last_col ? FIRST_RIGHT : FIRST_MID;
      FIRST_RIGHT: state_nxt = (row_cnt == LAST_ROW) ? FLUSH_WAIT : IDLE; // 2-row frame
      BODY_LEFT:   state_nxt = BODY_MID;
      BODY_MID:    state_nxt = i_last_col ? BODY_RIGHT : BODY_MID;
      BODY_RIGHT:  state_nxt = (row_cnt == LAST_ROW) ? FLUSH_WAIT : IDLE;
      FLUSH_WAIT:  state_nxt = vav_q ? FLUSH_WAIT : LAST_LEFT;
      LAST_LEFT:   state_nxt = LAST_MID;
      LAST_MID:    state_nxt = i_last_col ? LAST_RIGHT : LAST_MID;
      LAST_RIGHT:  state_nxt = IDLE;
      default:     state_nxt = IDLE;
    endcase
  end

  // last row is still in mem1, clock it out with no new input
  assign flush = (state == FLUSH_WAIT && !vav_q) || state == LAST_LEFT || state == LAST_MID;
  assign shift = act | flush;

  always_ff @(posedge clk) begin
    if (shift) begin
      bot_d1 <= pix_q;
      bot_d2 <= bot_d1;
      mid_d1 <= i_up1;
      mid_d2 <= mid_d1;
      top_d1 <= i_up2;
      top_d2 <= top_d1;
    end
  end

  assign at_left  = (state == FIRST_LEFT)  || (state == BODY_LEFT)  || (state == LAST_LEFT);
  assign at_right = (state == FIRST_RIGHT) || (state == BODY_RIGHT) || (state == LAST_RIGHT);

  // row replication at top and bottom border
  always_comb begin
    {t_l, t_c, t_r} = {top_d2, top_d1, i_up2};
    {b_l, b_c, b_r} = {bot_d2, bot_d1, pix_q};
    case (state)
      FIRST_LEFT, FIRST_MID, FIRST_RIGHT: {t_l, t_c, t_r} = {mid_d2, mid_d1, i_up1};
      LAST_LEFT, LAST_MID, LAST_RIGHT:    {b_l, b_c, b_r} = {mid_d2, mid_d1, i_up1};
      default: ;
    endcase
  end

  // column replication at left and right border
  always_comb begin
    o_win.tl = at_left  ? t_c : t_l;
    o_win.tm = t_c;
    o_win.tr = at_right ? t_c : t_r;
    o_win.ml = at_left  ? mid_d1 : mid_d2;
    o_win.mc = mid_d1;
    o_win.mr = at_right ? mid_d1 : i_up1;
    o_win.bl = at_left  ? b_c : b_l;
    o_win.bm = b_c;
    o_win.br = at_right ? b_c : b_r;
  end

  assign o_win_valid = (state != IDLE) && (state != FLUSH_WAIT);
  assign o_shift     = shift;
  assign o_pix       = pix_q;

endmodule

`default_nettype wire

//--- unsharp.f
+incdir+design
design/unsharp_pkg.sv
design/line_buffer.sv
design/window_former.sv
design/sharpen_pipe.sv
design/unsharp_top.sv
verif/tb_unsharp.sv

//--- verif/tb_unsharp.sv
`timescale 1ns/1ps
`default_nettype none

`include "unsharp_defines.svh"

module tb_unsharp import unsharp_pkg::*; ();

  localparam int W         = `UNSHARP_IMG_W;
  localparam int H         = `UNSHARP_IMG_H;
  localparam int NPIX      = W * H;
  localparam int MAX_TESTS = 8;
  localparam int TIMEOUT   = 200; // cycles allowed per output pixel

  logic    clk;
  logic    rstb;
  raster_t raster;
  pixel_t  o_pix;
  logic    o_valid;

  pixel_t  in_pix  [MAX_TESTS][NPIX]; // frames from the data file
  pixel_t  exp_pix [MAX_TESTS][NPIX]; // expected results, raster order
  string   names   [MAX_TESTS];
  int      n_tests;
  pixel_t  got_q [$];                 // results seen on the output
  int      seed = 20;
  int      tests_failed;
  int      pix_errors;
  logic    timed_out;
  logic    load_ok;

  unsharp_top u_dut (
    .clk      (clk),
    .rstb     (rstb),
    .i_raster (raster),
    .o_pix    (o_pix),
    .o_valid  (o_valid)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk; // 10 ns period

  // monitor, grab every flagged result
  always @(posedge clk) begin
    if (rstb && o_valid) begin
      got_q.push_back(o_pix);
    end
  end

  // name line opens a test, each row line holds 8 inputs then 8 expected
  task automatic load_tests();
    int    fd;
    int    cnt;
    int    row;
    int    v [16];
    string line;
    string name;
    fd      = $fopen("verif/unsharp_tests.txt", "r");
    n_tests = 0;
    row     = 0;
    load_ok = (fd != 0);
    if (fd == 0) return;
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.substr(0, 0) == "#") continue; // blank or comment
      if ($sscanf(line, "test %s", name) == 1) begin
        names[n_tests] = name;
        n_tests++;
        row = 0;
      end else begin
        cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7],
                      v[8], v[9], v[10], v[11], v[12], v[13], v[14], v[15]);
        if (cnt != 16 || n_tests == 0 || row >= H) load_ok = 1'b0;
        else begin
          for (int c = 0; c < W; c++) begin
            in_pix[n_tests-1][row*W+c]  = pixel_t'(v[c]);
            exp_pix[n_tests-1][row*W+c] = pixel_t'(v[c+8]);
          end
          row++;
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic idle_cycles(input int n, input logic vav);
    repeat (n) begin
      @(posedge clk);
      raster <= '{hav: 1'b0, vav: vav, pix: '0};
    end
  endtask

  task automatic drive_frame(input int t);
    int gap;
    for (int r = 0; r < H; r++) begin
      for (int c = 0; c < W; c++) begin
        @(posedge clk);
        raster <= '{hav: 1'b1, vav: 1'b1, pix: in_pix[t][r*W+c]};
      end
      if (r == H - 1) begin
        idle_cycles(20, 1'b0); // frame gap, covers the last-row flush
      end else begin
        gap = 2 + ($random(seed) & 3); // 2..5 cycles between rows
        idle_cycles(gap, 1'b1);
      end
    end
  endtask

  task automatic drive_all();
    for (int t = 0; t < n_tests; t++) begin
      drive_frame(t); // frames go out back to back
    end
  endtask

  task automatic check_frame(input int t);
    int     errs;
    int     waited;
    pixel_t got;
    errs = 0;
    for (int i = 0; i < NPIX; i++) begin
      waited = 0;
      while (got_q.size() == 0 && waited < TIMEOUT) begin
        @(negedge clk);
        waited++;
      end
      if (got_q.size() == 0) begin
        $display("timeout: test %s received %0d of %0d output pixels, %0d are missing",
                 names[t], i, NPIX, NPIX - i);
        timed_out = 1'b1;
        tests_failed++;
        return;
      end
      got = got_q.pop_front();
      if (got !== exp_pix[t][i]) begin
        $display("error: time %0t test %s pixel %0d expected %02h got %02h",
                 $time, names[t], i, exp_pix[t][i], got);
        errs++;
      end
    end
    pix_errors += errs;
    if (errs != 0) tests_failed++;
    $display("test %s: %0d pixels checked, %0d mismatches", names[t], NPIX, errs);
  endtask

  task automatic check_all();
    for (int t = 0; t < n_tests; t++) begin
      if (timed_out) break; // stream is out of step after a timeout
      check_frame(t);
    end
  endtask

  // nothing may come out before the first frame
  task automatic check_idle();
    int errs;
    errs = 0;
    repeat (30) begin
      @(negedge clk);
      if (o_valid !== 1'b0) begin
        $display("error: time %0t o_valid high with no input after reset", $time);
        errs++;
      end
    end
    if (errs != 0) tests_failed++;
    $display("test idle_after_reset: 30 cycles checked, %0d with o_valid high", errs);
  endtask

  initial begin
    rstb         = 1'b0;
    raster       = '0;
    tests_failed = 0;
    pix_errors   = 0;
    timed_out    = 1'b0;
    load_tests();
    if (!load_ok || n_tests == 0) begin
      $display("could not read the test frames from verif/unsharp_tests.txt");
      tests_failed++;
    end
    repeat (5) @(posedge clk);
    rstb <= 1'b1;
    check_idle();
    fork
      drive_all();
      check_all();
    join
    repeat (50) @(negedge clk); // let any stray result arrive
    if (got_q.size() != 0) begin
      $display("the DUT sent %0d output pixels more than expected", got_q.size());
      tests_failed++;
    end
    $display("tests run %0d, tests failed %0d, pixel errors %0d",
             n_tests + 1, tests_failed, pix_errors);
    if (tests_failed == 0 && !timed_out) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/unsharp_tests.txt
# "test <name>" opens a frame, then one line per row, top row first:
# 8 input pixels, then the 8 expected output pixels of that row, all hex
test flat_128
80 80 80 80 80 80 80 80  82 82 82 82 82 82 82 82
80 80 80 80 80 80 80 80  82 82 82 82 82 82 82 82
80 80 80 80 80 80 80 80  82 82 82 82 82 82 82 82
80 80 80 80 80 80 80 80  82 82 82 82 82 82 82 82
80 80 80 80 80 80 80 80  82 82 82 82 82 82 82 82
80 80 80 80 80 80 80 80  82 82 82 82 82 82 82 82
80 80 80 80 80 80 80 80  82 82 82 82 82 82 82 82
80 80 80 80 80 80 80 80  82 82 82 82 82 82 82 82
test bright_centre
40 40 40 40 40 40 40 40  41 41 41 41 41 41 41 41
40 40 40 40 40 40 40 40  41 41 41 41 41 41 41 41
40 40 40 40 40 40 40 40  41 41 2d 2d 2d 41 41 41
40 40 40 ff 40 40 40 40  41 41 2d ff 2d 41 41 41
40 40 40 40 40 40 40 40  41 41 2d 2d 2d 41 41 41
40 40 40 40 40 40 40 40  41 41 41 41 41 41 41 41
40 40 40 40 40 40 40 40  41 41 41 41 41 41 41 41
40 40 40 40 40 40 40 40  41 41 41 41 41 41 41 41
test bright_left_col
f0 10 10 10 10 10 10 10  ff 00 11 11 11 11 11 11
f0 10 10 10 10 10 10 10  ff 00 11 11 11 11 11 11
f0 10 10 10 10 10 10 10  ff 00 11 11 11 11 11 11
f0 10 10 10 10 10 10 10  ff 00 11 11 11 11 11 11
f0 10 10 10 10 10 10 10  ff 00 11 11 11 11 11 11
f0 10 10 10 10 10 10 10  ff 00 11 11 11 11 11 11
f0 10 10 10 10 10 10 10  ff 00 11 11 11 11 11 11
f0 10 10 10 10 10 10 10  ff 00 11 11 11 11 11 11
test dark_corner
c8 c8 c8 c8 c8 c8 c8 c8  cc cc cc cc cc cc cc cc
c8 c8 c8 c8 c8 c8 c8 c8  cc cc cc cc cc cc cc cc
c8 c8 c8 c8 c8 c8 c8 c8  cc cc cc cc cc cc cc cc
c8 c8 c8 c8 c8 c8 c8 c8  cc cc cc cc cc cc cc cc
c8 c8 c8 c8 c8 c8 c8 c8  cc cc cc cc cc cc cc cc
c8 c8 c8 c8 c8 c8 c8 c8  cc cc cc cc cc cc cc cc
c8 c8 c8 c8 c8 c8 c8 c8  cc cc cc cc cc cc e1 f7
c8 c8 c8 c8 c8 c8 c8 00  cc cc cc cc cc cc f7 00
